//--- list.f
common/id_pkg.sv
decode/instr_decoder.sv
decode/control_unit.sv
source/reg_file.sv
source/operand_select.sv
source/id_stage.sv
tb/tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_id_stage
FILELIST  := list.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

localparam logic [31:0] SEED     = 32'h0550_5f89;
localparam logic [1:0]  CHK_NONE = 2'd0;
localparam logic [1:0]  CHK_DBG  = 2'd1;
localparam logic [1:0]  CHK_DEC  = 2'd2;

localparam opcode_t LEGAL_OPS [18] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU, OP_SLTI,
    OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
localparam opcode_t LEGAL_FNS [12] = '{FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JALR, FN_ADDU,
    FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};

logic          i_clk;
logic          i_rst_n;
word_t         i_pc;
word_t         i_instr;
logic          i_hazard_detected;
reg_idx_t      i_wb_sel;
logic          i_wb_en;
word_t         i_wb_data;
logic          i_step;
reg_idx_t      i_dbg_sel;
ctrl_t         o_ctrl;
operands_t     o_operands;
instr_fields_t o_fields;
logic          o_illegal;
word_t         o_dbg_data;

word_t      shadow [REG_CNT];
logic [1:0] chk_mode   = CHK_NONE;
logic       finish_req = 1'b0;
logic       drained    = 1'b0;
string      test_name  = "none";
int         checks     = 0;
int         errors     = 0;

id_stage dut (.*);

initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
end

// Expected decode of one instruction against the shadow registers
function automatic void ref_decode(input word_t instr, input word_t pc, input logic hz,
                                   output ctrl_t c, output operands_t o, output logic ill);
    opcode_t  op;
    opcode_t  fn;
    reg_idx_t dst_idx;
    logic     shift;
    word_t    imm;
    word_t    rs_val;
    word_t    rt_val;
    op     = instr[31:26];
    fn     = instr[5:0];
    rs_val = shadow[instr[25:21]];
    rt_val = shadow[instr[20:16]];
    imm    = {{16{instr[15]}}, instr[15:0]};
    shift  = (op == OP_RTYPE) && (fn inside {FN_SLL, FN_SRL, FN_SRA});
    c      = '0;
    ill    = 1'b0;
    case (op)
        OP_RTYPE: begin
            case (fn)
                FN_ADDU:        c.alu_op = ALU_ADD;
                FN_SUBU:        c.alu_op = ALU_SUB;
                FN_AND:         c.alu_op = ALU_AND;
                FN_OR:          c.alu_op = ALU_OR;
                FN_XOR:         c.alu_op = ALU_XOR;
                FN_NOR:         c.alu_op = ALU_NOR;
                FN_SLT:         c.alu_op = ALU_SLT;
                FN_SLL:         c.alu_op = ALU_SLL;
                FN_SRL:         c.alu_op = ALU_SRL;
                FN_SRA:         c.alu_op = ALU_SRA;
                FN_JR, FN_JALR: c.agu_op = AGU_REGJUMP;
                default:        ill = 1'b1;
            endcase
            c.src_a       = shift ? SRC_A_RT : ((fn == FN_JALR) ? SRC_A_PC8 : SRC_A_RS);
            c.src_b       = shift ? SRC_B_SHAMT : ((fn == FN_JALR) ? SRC_B_ZERO : SRC_B_RT);
            c.jump        = fn inside {FN_JR, FN_JALR};
            c.jmp_trg_reg = c.jump;
            c.reg_wr_en   = (fn != FN_JR);
        end
        OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            c.src_b     = SRC_B_IMM;
            c.dst       = DST_RT;
            c.reg_wr_en = 1'b1;
            case (op)
                OP_SLTI: c.alu_op = ALU_SLT;
                OP_ANDI: c.alu_op = ALU_AND;
                OP_ORI:  c.alu_op = ALU_OR;
                OP_XORI: c.alu_op = ALU_XOR;
                OP_LUI:  c.alu_op = ALU_LUI;
                default: c.alu_op = ALU_ADD;
            endcase
            if (op inside {OP_ANDI, OP_ORI, OP_XORI}) imm = {16'h0000, instr[15:0]};
            if (op == OP_LUI) imm = {instr[15:0], 16'h0000};
        end
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW: begin
            c.src_b        = SRC_B_IMM;
            c.dst          = DST_RT;
            c.agu_op       = AGU_MEM;
            c.mem_size     = (op inside {OP_LB, OP_LBU, OP_SB}) ? MEM_BYTE :
                             ((op inside {OP_LH, OP_LHU, OP_SH}) ? MEM_HALF : MEM_WORD);
            c.mem_rd       = !(op inside {OP_SB, OP_SH, OP_SW});
            c.reg_wr_en    = c.mem_rd;
            c.wb_from_mem  = c.mem_rd;
            c.mem_wr_en    = !c.mem_rd;
            c.mem_unsigned = op inside {OP_LBU, OP_LHU};
        end
        OP_BEQ, OP_BNE: begin
            c.alu_op      = ALU_SUB;
            c.agu_op      = AGU_BRANCH;
            c.branch      = 1'b1;
            c.br_on_equal = (op == OP_BEQ);
        end
        OP_J:    c.jump = 1'b1;
        OP_JAL: begin
            c.src_a     = SRC_A_PC8;
            c.src_b     = SRC_B_ZERO;
            c.dst       = DST_LINK;
            c.reg_wr_en = 1'b1;
            c.jump      = 1'b1;
        end
        default: ill = 1'b1;
    endcase
    case (c.dst)
        DST_RT:   dst_idx = instr[20:16];
        DST_LINK: dst_idx = LINK_REG;
        default:  dst_idx = instr[15:11];
    endcase
    if (dst_idx == 5'd0) c.reg_wr_en = 1'b0;    // r0 writes dropped
    if (hz || ill) c = '0;                       // Bubble
    o.store_data = rt_val;
    case (c.src_a)
        SRC_A_RT:  o.alu_a = rt_val;
        SRC_A_PC8: o.alu_a = pc + 32'd8;
        default:   o.alu_a = rs_val;
    endcase
    case (c.src_b)
        SRC_B_IMM:   o.alu_b = imm;
        SRC_B_SHAMT: o.alu_b = word_t'(instr[10:6]);
        SRC_B_ZERO:  o.alu_b = '0;
        default:     o.alu_b = rt_val;
    endcase
    case (c.agu_op)
        AGU_MEM, AGU_REGJUMP: o.agu_base = rs_val;
        AGU_BRANCH:           o.agu_base = pc + 32'd4;
        default:              o.agu_base = '0;
    endcase
endfunction

// MIPS field positions, J-type target overlaps rs, rt and imm
function automatic instr_fields_t expected_fields(input word_t instr);
    instr_fields_t f;
    f.opcode = instr[31:26];
    f.rs     = instr[25:21];
    f.rt     = instr[20:16];
    f.rd     = instr[15:11];
    f.shamt  = instr[10:6];
    f.funct  = instr[5:0];
    f.imm16  = instr[15:0];
    f.target = instr[25:0];
    return f;
endfunction

function automatic word_t random_legal();
    int       k;
    reg_idx_t rt;
    reg_idx_t rd;
    k  = $urandom_range(0, 29);
    rt = ($urandom_range(0, 3) == 0) ? 5'd0 : reg_idx_t'($urandom);   // Hit r0 destinations
    rd = ($urandom_range(0, 3) == 0) ? 5'd0 : reg_idx_t'($urandom);
    if (k < 12) begin
        return {OP_RTYPE, reg_idx_t'($urandom), rt, rd, shamt_t'($urandom), LEGAL_FNS[k]};
    end
    return {LEGAL_OPS[k-12], reg_idx_t'($urandom), rt, 16'($urandom)};
endfunction

function automatic word_t random_illegal();
    word_t     w;
    ctrl_t     c;
    operands_t o;
    logic      ill;
    for (int t = 0; t < 100; t++) begin
        w = $urandom;
        if ($urandom_range(0, 1) == 1) w[31:26] = OP_RTYPE;
        ref_decode(w, '0, 1'b0, c, o, ill);
        if (ill) return w;
    end
    return 32'hffff_ffff;   // Opcode 0x3f is unused
endfunction

task automatic drive_decode(input word_t instr, input word_t pc, input logic hz,
                            input string name);
    @(posedge i_clk);
    i_instr           <= instr;
    i_pc              <= pc;
    i_hazard_detected <= hz;
    chk_mode          <= CHK_DEC;
    test_name         <= name;
endtask

task automatic write_reg(input reg_idx_t sel, input word_t data, input logic step);
    @(posedge i_clk);
    chk_mode  <= CHK_NONE;
    i_wb_sel  <= sel;
    i_wb_data <= data;
    i_wb_en   <= 1'b1;
    i_step    <= step;
    @(posedge i_clk);                                   // Write commits here
    if (step && (sel != 5'd0)) shadow[sel] = data;
    i_wb_en <= 1'b0;
    i_step  <= 1'b0;
endtask

task automatic read_back_all(input string name);
    for (int i = 0; i < REG_CNT; i++) begin
        @(posedge i_clk);
        i_dbg_sel <= reg_idx_t'(i);
        chk_mode  <= CHK_DBG;
        test_name <= name;
    end
endtask

initial begin : compare_outputs
    ctrl_t         exp_c;
    operands_t     exp_o;
    instr_fields_t exp_f;
    logic          exp_ill;
    forever begin
        @(negedge i_clk);
        if (chk_mode == CHK_DBG) begin
            checks++;
            if (o_dbg_data !== shadow[i_dbg_sel]) begin
                errors++;
                $display("[FAIL] %s: r%0d expected %h actual %h", test_name, i_dbg_sel,
                         shadow[i_dbg_sel], o_dbg_data);
            end
        end else if (chk_mode == CHK_DEC) begin
            ref_decode(i_instr, i_pc, i_hazard_detected, exp_c, exp_o, exp_ill);
            exp_f = expected_fields(i_instr);
            checks++;
            if (o_ctrl !== exp_c) begin
                errors++;
                $display("[FAIL] %s: instr %h ctrl expected %h actual %h", test_name, i_instr,
                         exp_c, o_ctrl);
            end
            if (o_operands !== exp_o) begin
                errors++;
                $display("[FAIL] %s: instr %h operands expected %h actual %h", test_name,
                         i_instr, exp_o, o_operands);
            end
            if (o_illegal !== exp_ill) begin
                errors++;
                $display("[FAIL] %s: instr %h illegal expected %b actual %b", test_name,
                         i_instr, exp_ill, o_illegal);
            end
            if (o_fields !== exp_f) begin
                errors++;
                $display("[FAIL] %s: instr %h fields expected %h actual %h", test_name,
                         i_instr, exp_f, o_fields);
            end
        end
        if (finish_req) drained = 1'b1;
    end
end

initial begin
    word_t w;
    word_t pc;
    void'($urandom(SEED));
    i_rst_n           = 1'b0;
    i_pc              = '0;
    i_instr           = '0;
    i_hazard_detected = 1'b0;
    i_wb_sel          = '0;
    i_wb_en           = 1'b0;
    i_wb_data         = '0;
    i_step            = 1'b0;
    i_dbg_sel         = '0;
    for (int i = 0; i < REG_CNT; i++) shadow[i] = '0;
    for (int n = 0; n < 8; n++) @(posedge i_clk);
    i_rst_n <= 1'b1;
    read_back_all("reset_zero");
    for (int i = 1; i < REG_CNT; i++) write_reg(reg_idx_t'(i), $urandom, 1'b1);
    for (int n = 0; n < 60; n++) begin
        write_reg(($urandom_range(0, 7) == 0) ? 5'd0 : reg_idx_t'($urandom), $urandom,
                  1'($urandom_range(0, 1)));
    end
    read_back_all("step_write");
    for (int n = 0; n < 300; n++) begin
        w  = random_legal();
        pc = $urandom & 32'hffff_fffc;
        drive_decode(w, pc, 1'b0, "legal_decode");
        drive_decode(w, pc, 1'b1, "hazard_bubble");
    end
    for (int n = 0; n < 80; n++) drive_decode(random_illegal(), $urandom, 1'b0, "illegal_word");
    @(posedge i_clk);
    chk_mode   <= CHK_NONE;
    finish_req <= 1'b1;
    for (int t = 0; (t < 10) && !drained; t++) @(posedge i_clk);
    if (!drained) begin
        errors++;
        $display("Compare process never completed its final pass");
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire word_t    i_pc,
    input  wire word_t    i_instr,
    input  wire           i_hazard_detected,
    input  wire reg_idx_t i_wb_sel,        // Write-back port from a later stage
    input  wire           i_wb_en,
    input  wire word_t    i_wb_data,
    input  wire           i_step,
    input  wire reg_idx_t i_dbg_sel,
    output ctrl_t         o_ctrl,
    output operands_t     o_operands,
    output instr_fields_t o_fields,
    output logic          o_illegal,
    output word_t         o_dbg_data
);

instr_kind_e kind;
ext_e        ext;
word_t       rs_data;
word_t       rt_data;

instr_decoder u_decoder (
    .i_instr   (i_instr),
    .o_fields  (o_fields),
    .o_kind    (kind),
    .o_illegal (o_illegal)
);

control_unit u_ctrl (
    .i_kind            (kind),
    .i_rd              (o_fields.rd),
    .i_rt              (o_fields.rt),
    .i_hazard_detected (i_hazard_detected),
    .o_ctrl            (o_ctrl),
    .o_ext             (ext)
);

reg_file u_regs (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs_sel   (o_fields.rs),
    .i_rt_sel   (o_fields.rt),
    .i_wb_sel   (i_wb_sel),
    .i_dbg_sel  (i_dbg_sel),
    .i_wb_en    (i_wb_en),
    .i_step     (i_step),
    .i_wb_data  (i_wb_data),
    .o_rs_data  (rs_data),
    .o_rt_data  (rt_data),
    .o_dbg_data (o_dbg_data)
);

operand_select u_opsel (
    .i_pc       (i_pc),
    .i_imm      (o_fields.imm16),
    .i_shamt    (o_fields.shamt),
    .i_ext      (ext),
    .i_src_a    (o_ctrl.src_a),
    .i_src_b    (o_ctrl.src_b),
    .i_agu_op   (o_ctrl.agu_op),
    .i_rs_data  (rs_data),
    .i_rt_data  (rt_data),
    .o_operands (o_operands)
);

endmodule

`default_nettype wire

//--- source/operand_select.sv
`timescale 1ns/10ps
`default_nettype none

module operand_select
    import id_pkg::*;
(
    input  wire word_t   i_pc,
    input  wire imm16_t  i_imm,
    input  wire shamt_t  i_shamt,
    input  wire ext_e    i_ext,
    input  wire src_a_e  i_src_a,
    input  wire src_b_e  i_src_b,
    input  wire agu_op_e i_agu_op,
    input  wire word_t   i_rs_data,
    input  wire word_t   i_rt_data,
    output operands_t    o_operands
);

word_t imm_ext;
word_t pc_plus4;
word_t pc_plus8;

assign pc_plus4 = i_pc + INSTR_BYTES;
assign pc_plus8 = pc_plus4 + INSTR_BYTES;   // Link address past the delay slot

always_comb begin
    case (i_ext)
        EXT_ZERO:  imm_ext = {16'h0000, i_imm};
        EXT_UPPER: imm_ext = {i_imm, 16'h0000};
        default:   imm_ext = {{16{i_imm[15]}}, i_imm};
    endcase
end

always_comb begin
    o_operands.store_data = i_rt_data;
    case (i_src_a)
        SRC_A_RT:  o_operands.alu_a = i_rt_data;   // Shifts operate on rt
        SRC_A_PC8: o_operands.alu_a = pc_plus8;
        default:   o_operands.alu_a = i_rs_data;
    endcase
    case (i_src_b)
        SRC_B_IMM:   o_operands.alu_b = imm_ext;
        SRC_B_SHAMT: o_operands.alu_b = word_t'(i_shamt);
        SRC_B_ZERO:  o_operands.alu_b = '0;
        default:     o_operands.alu_b = i_rt_data;
    endcase
    case (i_agu_op)
        AGU_MEM, AGU_REGJUMP: o_operands.agu_base = i_rs_data;
        AGU_BRANCH:           o_operands.agu_base = pc_plus4;
        default:              o_operands.agu_base = '0;
    endcase
end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import id_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire reg_idx_t i_rs_sel,
    input  wire reg_idx_t i_rt_sel,
    input  wire reg_idx_t i_wb_sel,
    input  wire reg_idx_t i_dbg_sel,
    input  wire           i_wb_en,
    input  wire           i_step,
    input  wire word_t    i_wb_data,
    output word_t         o_rs_data,
    output word_t         o_rt_data,
    output word_t         o_dbg_data
);

word_t regs [1:REG_CNT-1];    // r0 has no storage
logic  wr_fire;

assign wr_fire = i_wb_en && i_step && (i_wb_sel != '0);

always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        for (int i = 1; i < REG_CNT; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_fire) begin
        regs[i_wb_sel] <= i_wb_data;
    end
end

// Reads see the old value during a same-cycle write
assign o_rs_data  = (i_rs_sel == '0) ? '0 : regs[i_rs_sel];
assign o_rt_data  = (i_rt_sel == '0) ? '0 : regs[i_rt_sel];
assign o_dbg_data = (i_dbg_sel == '0) ? '0 : regs[i_dbg_sel];

a_r0_reads_zero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((i_rs_sel != '0) || (o_rs_data == '0)) &&
    ((i_rt_sel != '0) || (o_rt_data == '0)) &&
    ((i_dbg_sel != '0) || (o_dbg_data == '0))
) else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

//--- decode/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit
    import id_pkg::*;
(
    input  wire instr_kind_e i_kind,
    input  wire reg_idx_t    i_rd,
    input  wire reg_idx_t    i_rt,
    input  wire              i_hazard_detected,
    output ctrl_t            o_ctrl,
    output ext_e             o_ext
);

ctrl_t    raw_ctrl;
reg_idx_t dst_idx;

function automatic ctrl_t alu_reg(alu_op_e op, src_a_e a, src_b_e b, dst_e d);
    ctrl_t c;
    c           = '0;
    c.alu_op    = op;
    c.src_a     = a;
    c.src_b     = b;
    c.dst       = d;
    c.reg_wr_en = 1'b1;
    return c;
endfunction

function automatic ctrl_t mem_acc(mem_size_e sz, logic is_load, logic is_unsigned);
    ctrl_t c;
    c              = alu_reg(ALU_ADD, SRC_A_RS, SRC_B_IMM, DST_RT);
    c.agu_op       = AGU_MEM;
    c.mem_size     = sz;
    c.reg_wr_en    = is_load;
    c.mem_rd       = is_load;
    c.wb_from_mem  = is_load;
    c.mem_wr_en    = !is_load;
    c.mem_unsigned = is_unsigned;
    return c;
endfunction

always_comb begin
    raw_ctrl = '0;
    o_ext    = EXT_SIGN;
    case (i_kind)
        KIND_ADDU:  raw_ctrl = alu_reg(ALU_ADD, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_SUBU:  raw_ctrl = alu_reg(ALU_SUB, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_AND:   raw_ctrl = alu_reg(ALU_AND, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_OR:    raw_ctrl = alu_reg(ALU_OR,  SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_XOR:   raw_ctrl = alu_reg(ALU_XOR, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_NOR:   raw_ctrl = alu_reg(ALU_NOR, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_SLT:   raw_ctrl = alu_reg(ALU_SLT, SRC_A_RS, SRC_B_RT, DST_RD);
        KIND_SLL:   raw_ctrl = alu_reg(ALU_SLL, SRC_A_RT, SRC_B_SHAMT, DST_RD);
        KIND_SRL:   raw_ctrl = alu_reg(ALU_SRL, SRC_A_RT, SRC_B_SHAMT, DST_RD);
        KIND_SRA:   raw_ctrl = alu_reg(ALU_SRA, SRC_A_RT, SRC_B_SHAMT, DST_RD);
        KIND_ADDIU: raw_ctrl = alu_reg(ALU_ADD, SRC_A_RS, SRC_B_IMM, DST_RT);
        KIND_SLTI:  raw_ctrl = alu_reg(ALU_SLT, SRC_A_RS, SRC_B_IMM, DST_RT);
        KIND_ANDI, KIND_ORI, KIND_XORI: begin
            raw_ctrl = alu_reg(ALU_AND, SRC_A_RS, SRC_B_IMM, DST_RT);
            if (i_kind == KIND_ORI) raw_ctrl.alu_op = ALU_OR;
            if (i_kind == KIND_XORI) raw_ctrl.alu_op = ALU_XOR;
            o_ext = EXT_ZERO;                  // Logic immediates are unsigned
        end
        KIND_LUI: begin
            raw_ctrl = alu_reg(ALU_LUI, SRC_A_RS, SRC_B_IMM, DST_RT);
            o_ext    = EXT_UPPER;
        end
        KIND_LB:    raw_ctrl = mem_acc(MEM_BYTE, 1'b1, 1'b0);
        KIND_LBU:   raw_ctrl = mem_acc(MEM_BYTE, 1'b1, 1'b1);
        KIND_LH:    raw_ctrl = mem_acc(MEM_HALF, 1'b1, 1'b0);
        KIND_LHU:   raw_ctrl = mem_acc(MEM_HALF, 1'b1, 1'b1);
        KIND_LW:    raw_ctrl = mem_acc(MEM_WORD, 1'b1, 1'b0);
        KIND_SB:    raw_ctrl = mem_acc(MEM_BYTE, 1'b0, 1'b0);
        KIND_SH:    raw_ctrl = mem_acc(MEM_HALF, 1'b0, 1'b0);
        KIND_SW:    raw_ctrl = mem_acc(MEM_WORD, 1'b0, 1'b0);
        KIND_BEQ, KIND_BNE: begin
            raw_ctrl.alu_op      = ALU_SUB;    // Compare rs against rt
            raw_ctrl.agu_op      = AGU_BRANCH;
            raw_ctrl.branch      = 1'b1;
            raw_ctrl.br_on_equal = (i_kind == KIND_BEQ);
        end
        KIND_JR, KIND_JALR: begin
            if (i_kind == KIND_JALR) raw_ctrl = alu_reg(ALU_ADD, SRC_A_PC8, SRC_B_ZERO, DST_RD);
            raw_ctrl.agu_op      = AGU_REGJUMP;
            raw_ctrl.jump        = 1'b1;
            raw_ctrl.jmp_trg_reg = 1'b1;
        end
        KIND_J:     raw_ctrl.jump = 1'b1;
        KIND_JAL: begin
            raw_ctrl      = alu_reg(ALU_ADD, SRC_A_PC8, SRC_B_ZERO, DST_LINK);
            raw_ctrl.jump = 1'b1;
        end
        default:    raw_ctrl = '0;
    endcase
end

always_comb begin
    case (raw_ctrl.dst)
        DST_RT:   dst_idx = i_rt;
        DST_LINK: dst_idx = LINK_REG;
        default:  dst_idx = i_rd;
    endcase
end

always_comb begin
    o_ctrl = raw_ctrl;
    if (dst_idx == '0) o_ctrl.reg_wr_en = 1'b0;                       // r0 never written
    if (i_hazard_detected || (i_kind == KIND_ILLEGAL)) o_ctrl = '0;   // Bubble
end

always_comb begin
    a_mem_excl: assert final (!(o_ctrl.mem_rd && o_ctrl.mem_wr_en))
        else $error("load and store raised together");
    a_hazard_quiet: assert final (!i_hazard_detected || !(o_ctrl.reg_wr_en || o_ctrl.mem_wr_en))
        else $error("state write leaked through a bubble");
end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
    import id_pkg::*;
(
    input  wire word_t     i_instr,
    output instr_fields_t  o_fields,
    output instr_kind_e    o_kind,
    output logic           o_illegal
);

always_comb begin
    o_fields.opcode = i_instr[31:26];
    o_fields.rs     = i_instr[25:21];
    o_fields.rt     = i_instr[20:16];
    o_fields.rd     = i_instr[15:11];
    o_fields.shamt  = i_instr[10:6];
    o_fields.funct  = i_instr[5:0];
    o_fields.imm16  = i_instr[15:0];
    o_fields.target = i_instr[25:0];   // J-type overlaps rs/rt/imm
end

always_comb begin
    o_kind    = KIND_ILLEGAL;
    o_illegal = 1'b0;
    case (o_fields.opcode)
        OP_RTYPE: begin
            case (o_fields.funct)
                FN_SLL:  o_kind = KIND_SLL;
                FN_SRL:  o_kind = KIND_SRL;
                FN_SRA:  o_kind = KIND_SRA;
                FN_JR:   o_kind = KIND_JR;
                FN_JALR: o_kind = KIND_JALR;
                FN_ADDU: o_kind = KIND_ADDU;
                FN_SUBU: o_kind = KIND_SUBU;
                FN_AND:  o_kind = KIND_AND;
                FN_OR:   o_kind = KIND_OR;
                FN_XOR:  o_kind = KIND_XOR;
                FN_NOR:  o_kind = KIND_NOR;
                FN_SLT:  o_kind = KIND_SLT;
                default: o_illegal = 1'b1;     // Unknown funct
            endcase
        end
        OP_J:     o_kind = KIND_J;
        OP_JAL:   o_kind = KIND_JAL;
        OP_BEQ:   o_kind = KIND_BEQ;
        OP_BNE:   o_kind = KIND_BNE;
        OP_ADDIU: o_kind = KIND_ADDIU;
        OP_SLTI:  o_kind = KIND_SLTI;
        OP_ANDI:  o_kind = KIND_ANDI;
        OP_ORI:   o_kind = KIND_ORI;
        OP_XORI:  o_kind = KIND_XORI;
        OP_LUI:   o_kind = KIND_LUI;
        OP_LB:    o_kind = KIND_LB;
        OP_LH:    o_kind = KIND_LH;
        OP_LW:    o_kind = KIND_LW;
        OP_LBU:   o_kind = KIND_LBU;
        OP_LHU:   o_kind = KIND_LHU;
        OP_SB:    o_kind = KIND_SB;
        OP_SH:    o_kind = KIND_SH;
        OP_SW:    o_kind = KIND_SW;
        default:  o_illegal = 1'b1;            // Unknown opcode
    endcase
end

// Both case levels must agree on what counts as illegal
always_comb begin
    a_illegal_kind: assert final (o_illegal == (o_kind == KIND_ILLEGAL))
        else $error("illegal flag and kind disagree");
end

endmodule

`default_nettype wire

//--- common/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int DATA_W  = 32;
    localparam int REG_W   = 5;
    localparam int REG_CNT = 32;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [15:0]       imm16_t;
    typedef logic [25:0]       target_t;
    typedef logic [4:0]        shamt_t;
    typedef logic [5:0]        opcode_t;

    localparam word_t    INSTR_BYTES = 32'd4;
    localparam reg_idx_t LINK_REG    = 5'd31;   // JAL destination

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_LBU   = 6'h24;
    localparam opcode_t OP_LHU   = 6'h25;
    localparam opcode_t OP_SB    = 6'h28;
    localparam opcode_t OP_SH    = 6'h29;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam opcode_t FN_SLL  = 6'h00;
    localparam opcode_t FN_SRL  = 6'h02;
    localparam opcode_t FN_SRA  = 6'h03;
    localparam opcode_t FN_JR   = 6'h08;
    localparam opcode_t FN_JALR = 6'h09;
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;
    localparam opcode_t FN_NOR  = 6'h27;
    localparam opcode_t FN_SLT  = 6'h2a;

    typedef enum logic [4:0] {
        KIND_ILLEGAL, KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR, KIND_XOR, KIND_NOR,
        KIND_SLT, KIND_SLL, KIND_SRL, KIND_SRA, KIND_JR, KIND_JALR,
        KIND_ADDIU, KIND_SLTI, KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI,
        KIND_LB, KIND_LBU, KIND_LH, KIND_LHU, KIND_LW, KIND_SB, KIND_SH, KIND_SW,
        KIND_BEQ, KIND_BNE, KIND_J, KIND_JAL
    } instr_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {AGU_NONE, AGU_MEM, AGU_BRANCH, AGU_REGJUMP} agu_op_e;
    typedef enum logic [1:0] {SRC_A_RS, SRC_A_RT, SRC_A_PC8} src_a_e;
    typedef enum logic [1:0] {SRC_B_RT, SRC_B_IMM, SRC_B_SHAMT, SRC_B_ZERO} src_b_e;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_LINK} dst_e;
    typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} ext_e;
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   shamt;
        opcode_t  funct;
        imm16_t   imm16;
        target_t  target;
    } instr_fields_t;

    typedef struct packed {
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        dst_e      dst;
        agu_op_e   agu_op;
        mem_size_e mem_size;
        logic      jump;
        logic      branch;
        logic      br_on_equal;
        logic      jmp_trg_reg;
        logic      reg_wr_en;
        logic      mem_rd;
        logic      mem_wr_en;
        logic      wb_from_mem;
        logic      mem_unsigned;
    } ctrl_t;

    typedef struct packed {
        word_t alu_a;
        word_t alu_b;
        word_t agu_base;
        word_t store_data;
    } operands_t;

endpackage

`default_nettype wire
